// ==== project.f ====
verilog/iso_bus_pkg.sv
verilog/frame_timer.sv
verilog/shift_in.sv
verilog/shift_out.sv
verilog/board_status_rx.sv
verilog/board_ctrl_tx.sv
verilog/iso_bus_ctrl.sv
bench/iso_bus_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= iso_bus_tb
FILE_LIST ?= project.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# A $fatal in the testbench gives a nonzero exit status, which fails this target
sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/iso_bus_tb.sv ====
// Stops at the first mismatch; status words are driven one edge before a load edge to match the receiver
`timescale 1ns/1ps

module iso_bus_tb;

    import iso_bus_pkg::*;

    localparam int NUM_ROWS = 6;
    localparam int CLK_HALF_NS = 20;
    localparam int RESET_CYCLES = 8;
    // Frames watched for strobe spacing and config word rotation
    localparam int ROTATION_FRAMES = 6;
    localparam int LOAD_TIMEOUT = 3 * FRAME_BITS;

    // One line of stimulus with its inbound serial words
    typedef struct packed {
        board_ctrl_t ctrl;
        frame_word_t ovf;
        frame_word_t dirchan;
    } stim_row_t;

    logic          custom_srclk;
    logic          reset;
    board_ctrl_t   ctrl;
    logic          custom_adc_ovf;
    logic          custom_dirchan;
    board_status_t status;
    logic          reg_load;
    logic          spi_adc_cs;
    logic          spi_dac_cs;
    logic          custom_clksel;
    logic          custom_adc_hwcon;

    stim_row_t   stim [NUM_ROWS];
    frame_word_t hwcon_words [NUM_HWCON];

    // Rising edges since reset release, the release edge counting as 0
    int edge_count;

    iso_bus_ctrl dut0 (
        .custom_srclk     (custom_srclk),
        .reset            (reset),
        .ctrl             (ctrl),
        .custom_adc_ovf   (custom_adc_ovf),
        .custom_dirchan   (custom_dirchan),
        .status           (status),
        .reg_load         (reg_load),
        .spi_adc_cs       (spi_adc_cs),
        .spi_dac_cs       (spi_dac_cs),
        .custom_clksel    (custom_clksel),
        .custom_adc_hwcon (custom_adc_hwcon)
    );

    always #(CLK_HALF_NS) custom_srclk = ~custom_srclk;

    always @(posedge custom_srclk) begin
        if (reset) begin
            edge_count <= 0;
        end else begin
            edge_count <= edge_count + 1;
        end
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail: at %0t ns, %s is %0h, expected %0h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // Bit at position pos of a per-port frame as the board should see it
    // Pad bits above the ports are always zero
    function automatic logic port_frame_bit(input port_mask_t mask, input int pos,
                                            input logic active_low);
        if (pos >= NUM_PORTS) begin
            return 1'b0;
        end
        return mask[pos] ^ active_low;
    endfunction

    // Returns at a rising edge where reg_load is high, before the DUT updates
    task automatic wait_load();
        int cycles;
        cycles = 0;
        @(posedge custom_srclk);
        while (!reg_load) begin
            cycles++;
            if (cycles > LOAD_TIMEOUT) begin
                $display("Timeout: the load strobe never came within %0d cycles", LOAD_TIMEOUT);
                abort_run();
            end
            @(posedge custom_srclk);
        end
    endtask

    task automatic set_row(input int r, input port_mask_t adc_sel, input port_mask_t dac_sel,
                           input port_mask_t clksel, input frame_word_t ovf,
                           input frame_word_t dirchan);
        stim[r].ctrl.adc_sel = adc_sel;
        stim[r].ctrl.dac_sel = dac_sel;
        stim[r].ctrl.clksel = clksel;
        for (int i = 0; i < NUM_HWCON; i++) begin
            stim[r].ctrl.hwcon[i] = hwcon_words[i];
        end
        stim[r].ovf = ovf;
        stim[r].dirchan = dirchan;
    endtask

    task automatic load_table();
        // Four distinct words so a wrong slot shows up
        hwcon_words[0] = 8'h3C;
        hwcon_words[1] = 8'hA5;
        hwcon_words[2] = 8'h0F;
        hwcon_words[3] = 8'hD2;
        //      row  adc_sel  dac_sel  clksel   ovf    dirchan
        set_row(0, 4'b0001, 4'b1110, 4'b0101, 8'hA5, 8'h3C);
        set_row(1, 4'b1111, 4'b0000, 4'b1010, 8'h01, 8'hF0);
        set_row(2, 4'b0000, 4'b1111, 4'b1111, 8'h80, 8'h0F);
        set_row(3, 4'b1001, 4'b0110, 4'b0000, 8'hFF, 8'h96);
        set_row(4, 4'b0100, 4'b0010, 4'b1100, 8'h5A, 8'h69);
        set_row(5, 4'b1010, 4'b0101, 4'b0011, 8'h00, 8'hC3);
    endtask

    task automatic check_serial_idle();
        check("spi_adc_cs", 32'(spi_adc_cs), 0);
        check("spi_dac_cs", 32'(spi_dac_cs), 0);
        check("custom_clksel", 32'(custom_clksel), 0);
        check("custom_adc_hwcon", 32'(custom_adc_hwcon), 0);
        check("status", 32'(status), 0);
    endtask

    // Strobe spacing and config word rotation from the first edge after release
    task automatic check_rotation();
        int e;
        int frame_num;
        frame_word_t word;
        for (int c = 1; c < (ROTATION_FRAMES + 1) * FRAME_BITS; c++) begin
            @(posedge custom_srclk);
            @(negedge custom_srclk);
            e = edge_count;
            check("reg_load", 32'(reg_load), 32'(e % FRAME_BITS == FRAME_BITS - 1));
            if (e < FRAME_BITS) begin
                // Nothing loaded into the transmit registers yet
                check_serial_idle();
            end else begin
                frame_num = e / FRAME_BITS - 1;
                word = hwcon_words[frame_num % NUM_HWCON];
                check("custom_adc_hwcon", 32'(custom_adc_hwcon),
                      32'(word[FRAME_BITS - 1 - e % FRAME_BITS]));
            end
        end
    endtask

    task automatic run_row(input int r);
        stim_row_t row;
        int bit_idx;

        row = stim[r];

        wait_load();
        ctrl <= row.ctrl;
        // Receiver keeps the samples taken up to a load edge, so the MSB leads by one edge
        repeat (FRAME_BITS - 1) @(posedge custom_srclk);
        custom_adc_ovf <= row.ovf[FRAME_BITS - 1];
        custom_dirchan <= row.dirchan[FRAME_BITS - 1];

        for (int j = 0; j < FRAME_BITS; j++) begin
            @(posedge custom_srclk);
            if (j < FRAME_BITS - 1) begin
                custom_adc_ovf <= row.ovf[FRAME_BITS - 2 - j];
                custom_dirchan <= row.dirchan[FRAME_BITS - 2 - j];
            end
            @(negedge custom_srclk);
            bit_idx = FRAME_BITS - 1 - j;
            check("spi_adc_cs", 32'(spi_adc_cs),
                  32'(port_frame_bit(row.ctrl.adc_sel, bit_idx, 1'b1)));
            check("spi_dac_cs", 32'(spi_dac_cs),
                  32'(port_frame_bit(row.ctrl.dac_sel, bit_idx, 1'b1)));
            check("custom_clksel", 32'(custom_clksel),
                  32'(port_frame_bit(row.ctrl.clksel, bit_idx, 1'b0)));
        end

        // Status takes the word at the following load edge
        @(posedge custom_srclk);
        @(negedge custom_srclk);
        check("status.adc_ovf", 32'(status.adc_ovf), 32'(row.ovf));
        check("status.num_channels", 32'(status.num_channels),
              32'(row.dirchan[FRAME_BITS - 1 -: NUM_PORTS]));
        check("status.direction", 32'(status.direction), 32'(row.dirchan[NUM_PORTS - 1:0]));
    endtask

    initial begin
        custom_srclk = 1'b0;
        reset = 1'b1;
        ctrl = '0;
        custom_adc_ovf = 1'b0;
        custom_dirchan = 1'b0;
        load_table();

        // Everything quiet while reset is held
        repeat (RESET_CYCLES) begin
            @(posedge custom_srclk);
            @(negedge custom_srclk);
            check("reg_load", 32'(reg_load), 0);
            check_serial_idle();
        end
        @(posedge custom_srclk);
        reset <= 1'b0;
        ctrl <= stim[0].ctrl;
        @(negedge custom_srclk);
        check("reg_load", 32'(reg_load), 0);
        check_serial_idle();

        check_rotation();

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== verilog/iso_bus_ctrl.sv ====
// Single bit clock domain, no handshake; reg_load is the only framing signal seen by the board
`timescale 1ns/1ps

module iso_bus_ctrl (
    input  logic                       custom_srclk,
    input  logic                       reset,
    input  iso_bus_pkg::board_ctrl_t   ctrl,
    input  logic                       custom_adc_ovf,
    input  logic                       custom_dirchan,
    output iso_bus_pkg::board_status_t status,
    output logic                       reg_load,
    output logic                       spi_adc_cs,
    output logic                       spi_dac_cs,
    output logic                       custom_clksel,
    output logic                       custom_adc_hwcon
);

    import iso_bus_pkg::*;

    hwcon_index_t hwcon_index;

    // Frame boundary and config word slot
    frame_timer timer0 (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .reg_load     (reg_load),
        .hwcon_index  (hwcon_index)
    );

    // Inbound status streams
    board_status_rx rx0 (
        .custom_srclk   (custom_srclk),
        .reset          (reset),
        .reg_load       (reg_load),
        .adc_ovf_serial (custom_adc_ovf),
        .dirchan_serial (custom_dirchan),
        .status         (status)
    );

    // Outbound control streams
    board_ctrl_tx tx0 (
        .custom_srclk     (custom_srclk),
        .reset            (reset),
        .reg_load         (reg_load),
        .hwcon_index      (hwcon_index),
        .ctrl             (ctrl),
        .spi_adc_cs       (spi_adc_cs),
        .spi_dac_cs       (spi_dac_cs),
        .custom_clksel    (custom_clksel),
        .custom_adc_hwcon (custom_adc_hwcon)
    );

endmodule

// ==== verilog/board_ctrl_tx.sv ====
// Control changes take effect at the next load edge; selects go out active low in the lower nibble
`timescale 1ns/1ps

module board_ctrl_tx (
    input  logic                      custom_srclk,
    input  logic                      reset,
    input  logic                      reg_load,
    input  iso_bus_pkg::hwcon_index_t hwcon_index,
    input  iso_bus_pkg::board_ctrl_t  ctrl,
    output logic                      spi_adc_cs,
    output logic                      spi_dac_cs,
    output logic                      custom_clksel,
    output logic                      custom_adc_hwcon
);

    import iso_bus_pkg::*;

    // Upper bits of the per-port words are unused on the board
    localparam int PAD_BITS = FRAME_BITS - NUM_PORTS;

    frame_word_t adc_cs_word;
    frame_word_t dac_cs_word;
    frame_word_t clksel_word;
    frame_word_t hwcon_word;

    // Chip selects are active low on the board
    assign adc_cs_word = {{PAD_BITS{1'b0}}, ~ctrl.adc_sel};
    assign dac_cs_word = {{PAD_BITS{1'b0}}, ~ctrl.dac_sel};

    assign clksel_word = {{PAD_BITS{1'b0}}, ctrl.clksel};

    // One config word per frame, picked before the index steps on
    assign hwcon_word = ctrl.hwcon[hwcon_index];

    shift_out adc_cs_tx (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .reg_load     (reg_load),
        .word         (adc_cs_word),
        .serial_out   (spi_adc_cs)
    );

    shift_out dac_cs_tx (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .reg_load     (reg_load),
        .word         (dac_cs_word),
        .serial_out   (spi_dac_cs)
    );

    shift_out clksel_tx (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .reg_load     (reg_load),
        .word         (clksel_word),
        .serial_out   (custom_clksel)
    );

    // Board latches this into the register slot matching the rotation
    shift_out hwcon_tx (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .reg_load     (reg_load),
        .word         (hwcon_word),
        .serial_out   (custom_adc_hwcon)
    );

endmodule

// ==== verilog/board_status_rx.sv ====
// Status lags the serial streams by one frame plus one cycle and is all zero until the first load
`timescale 1ns/1ps

module board_status_rx (
    input  logic                       custom_srclk,
    input  logic                       reset,
    input  logic                       reg_load,
    input  logic                       adc_ovf_serial,
    input  logic                       dirchan_serial,
    output iso_bus_pkg::board_status_t status
);

    import iso_bus_pkg::*;

    frame_word_t ovf_word;
    frame_word_t dirchan_word;

    // ADC overflow flags, two per port
    shift_in ovf_rx (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .reg_load     (reg_load),
        .serial_in    (adc_ovf_serial),
        .word         (ovf_word)
    );

    // Channel count in the upper nibble, direction in the lower
    shift_in dirchan_rx (
        .custom_srclk (custom_srclk),
        .reset        (reset),
        .reg_load     (reg_load),
        .serial_in    (dirchan_serial),
        .word         (dirchan_word)
    );

    assign status.num_channels = dirchan_word[FRAME_BITS-1 -: NUM_PORTS];
    assign status.direction    = dirchan_word[NUM_PORTS-1:0];
    assign status.adc_ovf      = adc_ovf_t'(ovf_word);

endmodule

// ==== verilog/shift_out.sv ====
// Word is captured at load edges and sent MSB first from the next cycle; line idles low after a frame
`timescale 1ns/1ps

module shift_out (
    input  logic                     custom_srclk,
    input  logic                     reset,
    input  logic                     reg_load,
    input  iso_bus_pkg::frame_word_t word,
    output logic                     serial_out
);

    import iso_bus_pkg::*;

    frame_word_t shift_reg;

    // Load at the frame boundary, otherwise move the next bit up to the MSB
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            shift_reg <= '0;
        end else if (reg_load) begin
            shift_reg <= word;
        end else begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};
        end
    end

    // Board shifts in MSB first
    assign serial_out = shift_reg[FRAME_BITS-1];

endmodule

// ==== verilog/shift_in.sv ====
// Word updates only on load edges and holds the 8 bits sampled before that edge, oldest as MSB
`timescale 1ns/1ps

module shift_in (
    input  logic                     custom_srclk,
    input  logic                     reset,
    input  logic                     reg_load,
    input  logic                     serial_in,
    output iso_bus_pkg::frame_word_t word
);

    import iso_bus_pkg::*;

    frame_word_t shift_reg;

    // Sample the line every bit time, newest bit at the LSB
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            shift_reg <= '0;
        end else begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], serial_in};
        end
    end

    // Holding register keeps the word steady during the next frame
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            word <= '0;
        end else if (reg_load) begin
            word <= shift_reg;
        end
    end

endmodule

// ==== verilog/frame_timer.sv ====
// Free-running 8-bit frame; the first load strobe comes 7 edges after reset is released
`timescale 1ns/1ps

module frame_timer (
    input  logic                      custom_srclk,
    input  logic                      reset,
    output logic                      reg_load,
    output iso_bus_pkg::hwcon_index_t hwcon_index
);

    import iso_bus_pkg::*;

    // Position of the current bit within the frame
    bit_count_t bit_count;

    // Starts at 1 so the first frame boundary is 7 bit times out
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            bit_count <= bit_count_t'(1);
        end else begin
            bit_count <= bit_count + 1'b1;
        end
    end

    // One cycle in every frame
    assign reg_load = (bit_count == '0);

    // Config word slot moves on at each frame boundary, after the
    // transmitter has used the current value for its load
    always_ff @(posedge custom_srclk or posedge reset) begin
        if (reset) begin
            hwcon_index <= '0;
        end else if (reg_load) begin
            hwcon_index <= hwcon_index + 1'b1;
        end
    end

endmodule

// ==== verilog/iso_bus_pkg.sv ====
// Bus constants and types; the frame width is fixed at 8 by the board registers and is not configurable
package iso_bus_pkg;

    // Bits per frame, equal to the width of every board shift register
    localparam int FRAME_BITS = 8;

    // Converter ports on the isolated board
    localparam int NUM_PORTS = 4;

    // Hardware configuration words sent in rotation, one per frame
    localparam int NUM_HWCON = 4;

    typedef logic [FRAME_BITS-1:0] frame_word_t;
    typedef logic [$clog2(FRAME_BITS)-1:0] bit_count_t;
    typedef logic [NUM_PORTS-1:0] port_mask_t;
    typedef logic [$clog2(NUM_HWCON)-1:0] hwcon_index_t;

    // Two channels per port, MSB first: R3, L3, R2, L2, R1, L1, R0, L0
    typedef logic [2*NUM_PORTS-1:0] adc_ovf_t;

    // Everything sent to the board
    typedef struct packed {
        // Word 3 sits in the top byte
        frame_word_t [NUM_HWCON-1:0] hwcon;
        // 1 selects 24.576 MHz, 0 selects 11.2896 MHz
        port_mask_t clksel;
        port_mask_t dac_sel;
        port_mask_t adc_sel;
    } board_ctrl_t;

    // Everything the board reports back
    typedef struct packed {
        // 1 means 8 channels, 0 means 2 channels
        port_mask_t num_channels;
        // 1 means ADC, 0 means DAC
        port_mask_t direction;
        adc_ovf_t adc_ovf;
    } board_status_t;

endpackage
